//--- design/branch_hazard_detector.sv
`timescale 1ns/100ps
`default_nettype none

module branch_hazard_detector (
    // Operands compared by the branch in decode
    input  isa_pkg::reg_idx_t if_id_rs,
    input  isa_pkg::reg_idx_t if_id_rt,
    input  logic              id_branch,

    // Producer in EX
    input  logic              ex_reg_write,
    input  isa_pkg::reg_idx_t ex_dst,

    // Load in MEM
    input  logic              mem_mem_read,
    input  isa_pkg::reg_idx_t mem_dst,

    // Branch must hold in decode
    output logic              branch_wait
);

    ////////////////////
    // EX producer
    ////////////////////

    logic ex_live;
    logic ex_hit;

    // Writes to $zero are dropped
    assign ex_live = ex_reg_write & (ex_dst != isa_pkg::zero_reg);

    // Result is still inside the ALU this cycle
    assign ex_hit = ex_live & ((ex_dst == if_id_rs) | (ex_dst == if_id_rt));

    ////////////////////
    // MEM load
    ////////////////////

    logic mem_live;
    logic mem_hit;

    // Load data arrives at the end of MEM
    assign mem_live = mem_mem_read & (mem_dst != isa_pkg::zero_reg);

    assign mem_hit = mem_live & ((mem_dst == if_id_rs) | (mem_dst == if_id_rt));

    ////////////////////
    // Verdict
    ////////////////////

    // Comparator sits in decode, ahead of the EX forwarding muxes
    // Load into a branch operand therefore costs two slots
    assign branch_wait = id_branch & (ex_hit | mem_hit);

endmodule

`default_nettype wire

//--- design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    ////////////////////
    // Control word widths
    ////////////////////

    // ALU operation select driven by the main decoder
    localparam int alu_op_w = 4;

    // Write-back source select
    localparam int mem_to_reg_w = 2;

    ////////////////////
    // Control word types
    ////////////////////

    typedef logic [alu_op_w-1:0] alu_op_t;

    // Write-back source
    //   0 = ALU result
    //   1 = data memory
    //   2 = link address (PC + 8)
    typedef logic [mem_to_reg_w-1:0] mem_to_reg_t;

    ////////////////////
    // Bubble encodings
    ////////////////////

    // A bubble does no ALU work
    localparam alu_op_t bubble_alu_op = alu_op_t'(0);

    // Bubble selects the ALU result, which nobody writes back anyway
    localparam mem_to_reg_t wb_src_alu = mem_to_reg_t'(0);

endpackage

`default_nettype wire

//--- design/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  logic                  clk,
    input  logic                  rst_n,

    // Decode-stage operands
    input  isa_pkg::reg_idx_t     if_id_rs,
    input  isa_pkg::reg_idx_t     if_id_rt,
    input  isa_pkg::reg_idx_t     id_dst,
    input  logic                  id_branch,
    input  logic                  branch_taken,

    // Decoded control bundle
    input  logic                  reg_write,
    input  ctrl_pkg::alu_op_t     alu_op,
    input  logic                  alu_src,
    input  logic                  mem_write,
    input  logic                  mem_read,
    input  ctrl_pkg::mem_to_reg_t mem_to_reg,
    input  logic                  jump,
    input  logic                  jump_reg,

    // Front-end control
    output logic                  pc_write,
    output logic                  if_id_write,
    output logic                  if_id_flush,

    // Control word entering EX
    output logic                  ex_reg_write,
    output ctrl_pkg::alu_op_t     ex_alu_op,
    output logic                  ex_alu_src,
    output logic                  ex_mem_write,
    output logic                  ex_mem_read,
    output ctrl_pkg::mem_to_reg_t ex_mem_to_reg,
    output logic                  ex_jump,
    output logic                  ex_jump_reg,
    output isa_pkg::reg_idx_t     ex_dst
);

    ////////////////////
    // Internal nets
    ////////////////////

    // Detector verdicts
    logic load_use;
    logic branch_wait;

    // Load still in MEM
    logic              mem_mem_read;
    isa_pkg::reg_idx_t mem_dst;

    ////////////////////
    // Detectors
    ////////////////////

    load_use_detector u_load_use (
        .if_id_rs    (if_id_rs),
        .if_id_rt    (if_id_rt),
        .ex_mem_read (ex_mem_read),
        .ex_dst      (ex_dst),
        .load_use    (load_use)
    );

    branch_hazard_detector u_branch_hazard (
        .if_id_rs     (if_id_rs),
        .if_id_rt     (if_id_rt),
        .id_branch    (id_branch),
        .ex_reg_write (ex_reg_write),
        .ex_dst       (ex_dst),
        .mem_mem_read (mem_mem_read),
        .mem_dst      (mem_dst),
        .branch_wait  (branch_wait)
    );

    ////////////////////
    // Stage controller
    ////////////////////

    // Owns the pipeline record the detectors read back
    stage_control u_stage_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_use      (load_use),
        .branch_wait   (branch_wait),
        .branch_taken  (branch_taken),
        .reg_write     (reg_write),
        .alu_op        (alu_op),
        .alu_src       (alu_src),
        .mem_write     (mem_write),
        .mem_read      (mem_read),
        .mem_to_reg    (mem_to_reg),
        .jump          (jump),
        .jump_reg      (jump_reg),
        .id_dst        (id_dst),
        .pc_write      (pc_write),
        .if_id_write   (if_id_write),
        .if_id_flush   (if_id_flush),
        .ex_reg_write  (ex_reg_write),
        .ex_alu_op     (ex_alu_op),
        .ex_alu_src    (ex_alu_src),
        .ex_mem_write  (ex_mem_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_jump       (ex_jump),
        .ex_jump_reg   (ex_jump_reg),
        .ex_dst        (ex_dst),
        .mem_mem_read  (mem_mem_read),
        .mem_dst       (mem_dst)
    );

endmodule

`default_nettype wire

//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    ////////////////////
    // Register file geometry
    ////////////////////

    // 32 architectural registers
    localparam int reg_idx_w = 5;

    // Register number as it appears in rs, rt and rd fields
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    ////////////////////
    // Special registers
    ////////////////////

    // $zero reads as 0 and ignores writes
    // A write to it is never a real producer
    localparam reg_idx_t zero_reg = reg_idx_t'(0);

    // Field layout of an R-type word, for orientation
    //   [31:26] opcode
    //   [25:21] rs
    //   [20:16] rt
    //   [15:11] rd
    //   [10:6]  shamt
    //   [5:0]   funct
    // Only the register fields reach the hazard logic

endpackage

`default_nettype wire

//--- design/load_use_detector.sv
`timescale 1ns/100ps
`default_nettype none

module load_use_detector (
    // Sources of the instruction in decode
    input  isa_pkg::reg_idx_t if_id_rs,
    input  isa_pkg::reg_idx_t if_id_rt,

    // Instruction in EX
    input  logic              ex_mem_read,
    input  isa_pkg::reg_idx_t ex_dst,

    // Decode must wait one cycle
    output logic              load_use
);

    ////////////////////
    // Operand match
    ////////////////////

    logic dst_live;
    logic rs_hit;
    logic rt_hit;

    // Load into $zero produces nothing
    assign dst_live = (ex_dst != isa_pkg::zero_reg);

    // Either source waits on the load result
    assign rs_hit = (ex_dst == if_id_rs);
    assign rt_hit = (ex_dst == if_id_rt);

    ////////////////////
    // Verdict
    ////////////////////

    // Load data only exists after MEM
    // Forwarding cannot cover the very next instruction
    // so hold decode for one slot
    assign load_use = ex_mem_read & dst_live & (rs_hit | rt_hit);

endmodule

`default_nettype wire

//--- design/stage_control.sv
`timescale 1ns/100ps
`default_nettype none

module stage_control (
    input  logic                  clk,
    input  logic                  rst_n,

    // Detector verdicts
    input  logic                  load_use,
    input  logic                  branch_wait,

    // Decode outcome
    input  logic                  branch_taken,

    // Decoded control bundle
    input  logic                  reg_write,
    input  ctrl_pkg::alu_op_t     alu_op,
    input  logic                  alu_src,
    input  logic                  mem_write,
    input  logic                  mem_read,
    input  ctrl_pkg::mem_to_reg_t mem_to_reg,
    input  logic                  jump,
    input  logic                  jump_reg,
    input  isa_pkg::reg_idx_t     id_dst,

    // Front-end control
    output logic                  pc_write,
    output logic                  if_id_write,
    output logic                  if_id_flush,

    // ID/EX record
    output logic                  ex_reg_write,
    output ctrl_pkg::alu_op_t     ex_alu_op,
    output logic                  ex_alu_src,
    output logic                  ex_mem_write,
    output logic                  ex_mem_read,
    output ctrl_pkg::mem_to_reg_t ex_mem_to_reg,
    output logic                  ex_jump,
    output logic                  ex_jump_reg,
    output isa_pkg::reg_idx_t     ex_dst,

    // EX/MEM record
    output logic                  mem_mem_read,
    output isa_pkg::reg_idx_t     mem_dst
);

    ////////////////////
    // Stall and flush
    ////////////////////

    logic stall;

    // Any detector holds decode
    assign stall = load_use | branch_wait;

    // PC and IF/ID freeze together
    assign pc_write    = ~stall;
    assign if_id_write = ~stall;

    // Redirect kills the fetched slot
    // A stalled redirect is decided again next cycle
    assign if_id_flush = ~stall & (branch_taken | jump | jump_reg);

    ////////////////////
    // ID/EX record
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_reg_write  <= 1'b0;
            ex_alu_op     <= ctrl_pkg::bubble_alu_op;
            ex_alu_src    <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_to_reg <= ctrl_pkg::wb_src_alu;
            ex_jump       <= 1'b0;
            ex_jump_reg   <= 1'b0;
            ex_dst        <= isa_pkg::zero_reg;
        end else if (stall) begin
            // Bubble into EX while decode waits
            ex_reg_write  <= 1'b0;
            ex_alu_op     <= ctrl_pkg::bubble_alu_op;
            ex_alu_src    <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_to_reg <= ctrl_pkg::wb_src_alu;
            ex_jump       <= 1'b0;
            ex_jump_reg   <= 1'b0;
            ex_dst        <= isa_pkg::zero_reg;
        end else begin
            ex_reg_write  <= reg_write;
            ex_alu_op     <= alu_op;
            ex_alu_src    <= alu_src;
            ex_mem_write  <= mem_write;
            ex_mem_read   <= mem_read;
            ex_mem_to_reg <= mem_to_reg;
            ex_jump       <= jump;
            ex_jump_reg   <= jump_reg;
            ex_dst        <= id_dst;
        end
    end

    ////////////////////
    // EX/MEM record
    ////////////////////

    // Only what the branch check needs moves on
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_mem_read <= 1'b0;
            mem_dst      <= isa_pkg::zero_reg;
        end else begin
            mem_mem_read <= ex_mem_read;
            mem_dst      <= ex_dst;
        end
    end

endmodule

`default_nettype wire

//--- hazard_unit.f
design/isa_pkg.sv
design/ctrl_pkg.sv
design/load_use_detector.sv
design/branch_hazard_detector.sv
design/stage_control.sv
design/hazard_unit.sv
testbench/hazard_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build the hazard unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module hazard_unit_tb \
    -f hazard_unit.f \
    -o hazard_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/hazard_unit_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Test passed$"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- testbench/hazard_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit_tb;

    ////////////////////
    // Run limits
    ////////////////////

    localparam int reset_cycles = 5;
    localparam int indep_count  = 24;
    localparam int max_tries    = 4;
    // Directed sequences, stalls and drains take about 70 cycles
    localparam int max_cycles   = 2 * (reset_cycles + indep_count + 70);

    logic clk = 1'b0;
    logic rst_n;

    // Decode-stage inputs
    isa_pkg::reg_idx_t     if_id_rs;
    isa_pkg::reg_idx_t     if_id_rt;
    isa_pkg::reg_idx_t     id_dst;
    logic                  id_branch;
    logic                  branch_taken;
    logic                  reg_write;
    ctrl_pkg::alu_op_t     alu_op;
    logic                  alu_src;
    logic                  mem_write;
    logic                  mem_read;
    ctrl_pkg::mem_to_reg_t mem_to_reg;
    logic                  jump;
    logic                  jump_reg;

    // DUT outputs
    logic                  pc_write;
    logic                  if_id_write;
    logic                  if_id_flush;
    logic                  ex_reg_write;
    ctrl_pkg::alu_op_t     ex_alu_op;
    logic                  ex_alu_src;
    logic                  ex_mem_write;
    logic                  ex_mem_read;
    ctrl_pkg::mem_to_reg_t ex_mem_to_reg;
    logic                  ex_jump;
    logic                  ex_jump_reg;
    isa_pkg::reg_idx_t     ex_dst;

    // Next instruction presented to decode
    isa_pkg::reg_idx_t     n_rs;
    isa_pkg::reg_idx_t     n_rt;
    isa_pkg::reg_idx_t     n_dst;
    logic                  n_branch;
    logic                  n_taken;
    logic                  n_reg_write;
    ctrl_pkg::alu_op_t     n_alu_op;
    logic                  n_alu_src;
    logic                  n_mem_write;
    logic                  n_mem_read;
    ctrl_pkg::mem_to_reg_t n_mem_to_reg;
    logic                  n_jump;
    logic                  n_jump_reg;

    // Reference ID/EX record
    logic                  m_ex_reg_write;
    ctrl_pkg::alu_op_t     m_ex_alu_op;
    logic                  m_ex_alu_src;
    logic                  m_ex_mem_write;
    logic                  m_ex_mem_read;
    ctrl_pkg::mem_to_reg_t m_ex_mem_to_reg;
    logic                  m_ex_jump;
    logic                  m_ex_jump_reg;
    isa_pkg::reg_idx_t     m_ex_dst;

    // Reference EX/MEM record
    logic                  m_mem_mem_read;
    isa_pkg::reg_idx_t     m_mem_dst;

    int          error_count  = 0;
    int          check_count  = 0;
    int          flush_cycles = 0;
    int          cycle_count  = 0;

    always #5 clk = ~clk;

    hazard_unit dut_i (.*);

    ////////////////////
    // Checking
    ////////////////////

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // Whole control word entering EX against the model
    task automatic verify_ex_outputs();
        check("ex_reg_write", 32'(ex_reg_write), 32'(m_ex_reg_write));
        check("ex_alu_op", 32'(ex_alu_op), 32'(m_ex_alu_op));
        check("ex_alu_src", 32'(ex_alu_src), 32'(m_ex_alu_src));
        check("ex_mem_write", 32'(ex_mem_write), 32'(m_ex_mem_write));
        check("ex_mem_read", 32'(ex_mem_read), 32'(m_ex_mem_read));
        check("ex_mem_to_reg", 32'(ex_mem_to_reg), 32'(m_ex_mem_to_reg));
        check("ex_jump", 32'(ex_jump), 32'(m_ex_jump));
        check("ex_jump_reg", 32'(ex_jump_reg), 32'(m_ex_jump_reg));
        check("ex_dst", 32'(ex_dst), 32'(m_ex_dst));
    endtask

    task automatic clear_model();
        m_ex_reg_write  = 1'b0;
        m_ex_alu_op     = '0;
        m_ex_alu_src    = 1'b0;
        m_ex_mem_write  = 1'b0;
        m_ex_mem_read   = 1'b0;
        m_ex_mem_to_reg = '0;
        m_ex_jump       = 1'b0;
        m_ex_jump_reg   = 1'b0;
        m_ex_dst        = '0;
        m_mem_mem_read  = 1'b0;
        m_mem_dst       = '0;
    endtask

    ////////////////////
    // Instruction builders
    ////////////////////

    task automatic nop_instr();
        n_rs         = '0;
        n_rt         = '0;
        n_dst        = '0;
        n_branch     = 1'b0;
        n_taken      = 1'b0;
        n_reg_write  = 1'b0;
        n_alu_op     = '0;
        n_alu_src    = 1'b0;
        n_mem_write  = 1'b0;
        n_mem_read   = 1'b0;
        n_mem_to_reg = '0;
        n_jump       = 1'b0;
        n_jump_reg   = 1'b0;
    endtask

    // R-type add
    task automatic alu_instr(input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt,
                             input isa_pkg::reg_idx_t dst);
        nop_instr();
        n_rs        = rs;
        n_rt        = rt;
        n_dst       = dst;
        n_reg_write = 1'b1;
        n_alu_op    = 4'd2;
    endtask

    // lw dst, 0(base)
    // Destination sits in the rt field
    task automatic load_instr(input isa_pkg::reg_idx_t base, input isa_pkg::reg_idx_t dst);
        nop_instr();
        n_rs         = base;
        n_rt         = dst;
        n_dst        = dst;
        n_reg_write  = 1'b1;
        n_alu_op     = 4'd2;
        n_alu_src    = 1'b1;
        n_mem_read   = 1'b1;
        n_mem_to_reg = 2'd1;
    endtask

    task automatic branch_instr(input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt,
                                input logic taken);
        nop_instr();
        n_rs     = rs;
        n_rt     = rt;
        n_branch = 1'b1;
        n_taken  = taken;
    endtask

    ////////////////////
    // Pipeline stepping
    ////////////////////

    task automatic drive_next();
        if_id_rs     <= n_rs;
        if_id_rt     <= n_rt;
        id_dst       <= n_dst;
        id_branch    <= n_branch;
        branch_taken <= n_taken;
        reg_write    <= n_reg_write;
        alu_op       <= n_alu_op;
        alu_src      <= n_alu_src;
        mem_write    <= n_mem_write;
        mem_read     <= n_mem_read;
        mem_to_reg   <= n_mem_to_reg;
        jump         <= n_jump;
        jump_reg     <= n_jump_reg;
    endtask

    // One decode slot checked mid-cycle
    // Model then takes the edge
    task automatic issue(output logic stalled);
        logic hit_ex;
        logic hit_mem;
        logic exp_stall;
        logic exp_flush;
        @(posedge clk);
        drive_next();
        @(negedge clk);
        hit_ex = (m_ex_dst != isa_pkg::zero_reg) && (m_ex_dst == n_rs || m_ex_dst == n_rt);
        hit_mem = (m_mem_dst != isa_pkg::zero_reg) && (m_mem_dst == n_rs || m_mem_dst == n_rt);
        // Load-use, or a branch waiting on EX or on a load in MEM
        exp_stall = (m_ex_mem_read && hit_ex)
                    || (n_branch && ((m_ex_reg_write && hit_ex) || (m_mem_mem_read && hit_mem)));
        exp_flush = !exp_stall && (n_taken || n_jump || n_jump_reg);
        check("pc_write", 32'(pc_write), 32'(!exp_stall));
        check("if_id_write", 32'(if_id_write), 32'(!exp_stall));
        check("if_id_flush", 32'(if_id_flush), 32'(exp_flush));
        verify_ex_outputs();
        if (if_id_flush) flush_cycles++;
        m_mem_mem_read = m_ex_mem_read;
        m_mem_dst      = m_ex_dst;
        if (exp_stall) begin
            clear_ex_only();
        end else begin
            m_ex_reg_write  = n_reg_write;
            m_ex_alu_op     = n_alu_op;
            m_ex_alu_src    = n_alu_src;
            m_ex_mem_write  = n_mem_write;
            m_ex_mem_read   = n_mem_read;
            m_ex_mem_to_reg = n_mem_to_reg;
            m_ex_jump       = n_jump;
            m_ex_jump_reg   = n_jump_reg;
            m_ex_dst        = n_dst;
        end
        // Hold as the DUT reports it
        stalled = !pc_write;
    endtask

    // Bubble into the model's EX slot
    task automatic clear_ex_only();
        logic keep_read;
        isa_pkg::reg_idx_t keep_dst;
        keep_read = m_mem_mem_read;
        keep_dst  = m_mem_dst;
        clear_model();
        m_mem_mem_read = keep_read;
        m_mem_dst      = keep_dst;
    endtask

    // Present one instruction until decode accepts it
    task automatic execute(output int stalls);
        logic stalled;
        int tries;
        stalls  = 0;
        tries   = 0;
        stalled = 1'b1;
        while (stalled && tries < max_tries) begin
            issue(stalled);
            if (stalled) stalls++;
            tries++;
        end
        if (stalled) begin
            error_count++;
            $display("Decode held one instruction for %0d cycles and never advanced", max_tries);
        end
    endtask

    // Two nops push any producer out of EX and MEM
    task automatic drain();
        int stalls;
        nop_instr();
        execute(stalls);
        execute(stalls);
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        rst_n <= 1'b0;
        nop_instr();
        drive_next();
        repeat (cycles) @(posedge clk);
        rst_n <= 1'b1;
        clear_model();
        @(negedge clk);
        verify_ex_outputs();
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    // Sources from 16..31 and destinations from 1..15 never collide
    task automatic independent_stream();
        int stalls;
        for (int i = 0; i < indep_count; i++) begin
            nop_instr();
            n_rs         = isa_pkg::reg_idx_t'($urandom_range(31, 16));
            n_rt         = isa_pkg::reg_idx_t'($urandom_range(31, 16));
            n_dst        = isa_pkg::reg_idx_t'($urandom_range(15, 1));
            n_reg_write  = 1'($urandom_range(1, 0));
            n_alu_op     = ctrl_pkg::alu_op_t'($urandom_range(15, 0));
            n_alu_src    = 1'($urandom_range(1, 0));
            n_mem_write  = 1'($urandom_range(1, 0));
            n_mem_read   = 1'($urandom_range(1, 0));
            n_mem_to_reg = ctrl_pkg::mem_to_reg_t'($urandom_range(2, 0));
            execute(stalls);
            check("stall_cycles", 32'(stalls), 32'd0);
        end
        drain();
    endtask

    task automatic load_use_stalls();
        int stalls;
        load_instr(5'd3, 5'd8);
        execute(stalls);
        alu_instr(5'd8, 5'd4, 5'd10);
        execute(stalls);
        check("stall_cycles", 32'(stalls), 32'd1);
        drain();
        load_instr(5'd3, 5'd8);
        execute(stalls);
        alu_instr(5'd4, 5'd8, 5'd10);
        execute(stalls);
        check("stall_cycles", 32'(stalls), 32'd1);
        drain();
        // Load into $zero
        load_instr(5'd3, 5'd0);
        execute(stalls);
        alu_instr(5'd0, 5'd0, 5'd10);
        execute(stalls);
        check("stall_cycles", 32'(stalls), 32'd0);
        drain();
    endtask

    task automatic branch_operand_stalls();
        int stalls;
        alu_instr(5'd2, 5'd3, 5'd7);
        execute(stalls);
        branch_instr(5'd7, 5'd1, 1'b0);
        execute(stalls);
        check("stall_cycles", 32'(stalls), 32'd1);
        drain();
        load_instr(5'd2, 5'd7);
        execute(stalls);
        branch_instr(5'd1, 5'd7, 1'b0);
        execute(stalls);
        check("stall_cycles", 32'(stalls), 32'd2);
        drain();
    endtask

    task automatic redirect_flush();
        int stalls;
        int flushes_before;
        flushes_before = flush_cycles;
        branch_instr(5'd1, 5'd2, 1'b1);
        execute(stalls);
        nop_instr();
        n_jump = 1'b1;
        execute(stalls);
        nop_instr();
        n_jump_reg = 1'b1;
        n_rs       = 5'd31;
        execute(stalls);
        check("flush_cycles", 32'(flush_cycles - flushes_before), 32'd3);
        // Taken branch on a load result flushes only when it leaves decode
        load_instr(5'd2, 5'd6);
        execute(stalls);
        flushes_before = flush_cycles;
        branch_instr(5'd6, 5'd1, 1'b1);
        execute(stalls);
        check("stall_cycles", 32'(stalls), 32'd2);
        check("flush_cycles", 32'(flush_cycles - flushes_before), 32'd1);
        drain();
        // jr on a load-use
        load_instr(5'd2, 5'd6);
        execute(stalls);
        flushes_before = flush_cycles;
        nop_instr();
        n_jump_reg = 1'b1;
        n_rs       = 5'd6;
        execute(stalls);
        check("stall_cycles", 32'(stalls), 32'd1);
        check("flush_cycles", 32'(flush_cycles - flushes_before), 32'd1);
        drain();
    endtask

    task automatic reset_clears_record();
        int stalls;
        load_instr(5'd2, 5'd9);
        execute(stalls);
        apply_reset(2);
        // Former load target is free after reset
        alu_instr(5'd9, 5'd9, 5'd11);
        execute(stalls);
        check("stall_cycles", 32'(stalls), 32'd0);
        drain();
    endtask

    ////////////////////
    // Sequence and limits
    ////////////////////

    initial begin
        void'($urandom(32'h9357_9808));
        rst_n <= 1'b0;
        nop_instr();
        drive_next();
        clear_model();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        independent_stream();
        load_use_stalls();
        branch_operand_stalls();
        redirect_flush();
        reset_clears_record();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", max_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
